/* hw/dram_consts.svh */
`ifndef DRAM_CONSTS_SVH
`define DRAM_CONSTS_SVH

// timing values in controller clock cycles
`define DRAM_T_RCD 4
`define DRAM_T_RAS 10
`define DRAM_T_RP 4
`define DRAM_T_RFC 20

// average spacing of REF commands
`define DRAM_T_REFI 200

// latency from RD/WR issue to the data beat
`define DRAM_T_RL 3
`define DRAM_T_WL 2

// wide enough for the refresh interval
`define DRAM_CNT_W 10

// address split, row on top
`define DRAM_ROW_W 12
`define DRAM_BANK_W 2
`define DRAM_COL_W 8

`endif

/* hw/dram_cmd_pkg.sv */
`include "dram_consts.svh"

package dram_cmd_pkg;

    // issue states last one cycle, the -ING states wait on the counter
    typedef enum logic [3:0] {
        IDLE,
        ACTIVATE,
        ACTIVATING,
        READ,
        READING,
        WRITE,
        WRITING,
        PRECHARGE,
        PRECHARGING,
        REFRESH,
        REFRESHING
    } cmd_state_t;

    // opcodes on the DRAM command port
    typedef enum logic [2:0] {
        NOP,
        ACT,
        RD,
        WR,
        PRE,
        REF
    } dram_op_t;

    // one command beat on the DRAM port
    typedef struct packed {
        dram_op_t                  op;
        logic [`DRAM_BANK_W-1:0]   bank;
        logic [`DRAM_ROW_W-1:0]    row;
        logic [`DRAM_COL_W-1:0]    col;
    } dram_cmd_t;

endpackage

/* hw/dram_addr_pkg.sv */
`include "dram_consts.svh"

package dram_addr_pkg;

    typedef logic [31:0] dram_word_t;

    // field view of a word address, row most significant
    typedef struct packed {
        logic [`DRAM_ROW_W-1:0]    row;
        logic [`DRAM_BANK_W-1:0]   bank;
        logic [`DRAM_COL_W-1:0]    col;
    } dram_loc_t;

    // same bits seen as a flat word index or as row/bank/col
    typedef union packed {
        logic [`DRAM_ROW_W+`DRAM_BANK_W+`DRAM_COL_W-1:0] word;
        dram_loc_t                                     loc;
    } dram_addr_u;

    // host request held for the length of one access
    typedef struct packed {
        logic       we;
        dram_addr_u addr;
        dram_word_t wdata;
    } wb_req_t;

endpackage

/* hw/flex_counter.sv */
`include "dram_consts.svh"

module flex_counter #(
    parameter int N = `DRAM_CNT_W
) (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         enable,
    input  logic [N-1:0] count_load,
    output logic [N-1:0] count,
    output logic         count_done
);

    localparam logic [N-1:0] ONE = 1;

    // load wins over counting, then run down and park at zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (enable) begin
            count <= count_load;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last cycle of the wait, so the FSM leaves on time
    assign count_done = (count == ONE);

endmodule

/* hw/timing_signal.sv */
`include "dram_consts.svh"

module timing_signal
    import dram_cmd_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  cmd_state_t cmd_state,
    output logic       t_act_done,
    output logic       t_rd_done,
    output logic       t_wr_done,
    output logic       t_pre_done,
    output logic       t_ref_done,
    output logic       rf_req,
    output logic       rd_en,
    output logic       wr_en
);

    localparam int CW = `DRAM_CNT_W;

    localparam logic [CW-1:0] LD_RCD    = `DRAM_T_RCD;
    localparam logic [CW-1:0] LD_RL     = `DRAM_T_RL;
    localparam logic [CW-1:0] LD_WL     = `DRAM_T_WL;
    localparam logic [CW-1:0] LD_RP     = `DRAM_T_RP;
    localparam logic [CW-1:0] LD_RFC    = `DRAM_T_RFC;
    localparam logic [CW-1:0] REFI_V    = `DRAM_T_REFI;
    localparam logic [CW-1:0] RAS_START = `DRAM_T_RAS - 1;
    // single beat, data sits in the last wait cycle
    localparam logic [CW-1:0] BEAT_LEN  = 1;

    logic [CW-1:0] time_load;
    logic [CW-1:0] time_count;
    logic          time_en;
    logic          time_done;

    logic [CW-1:0] ras_left;
    logic [CW-1:0] refresh_count;
    logic [CW-1:0] next_refresh_count;
    logic [CW-1:0] refresh_limit;
    logic [CW-1:0] next_refresh_limit;

    always_comb begin
        time_en    = 1'b0;
        time_load  = '0;
        t_act_done = 1'b0;
        t_rd_done  = 1'b0;
        t_wr_done  = 1'b0;
        t_pre_done = 1'b0;
        t_ref_done = 1'b0;
        rd_en      = 1'b0;
        wr_en      = 1'b0;

        case (cmd_state)
            ACTIVATE: begin
                time_en   = 1'b1;
                time_load = LD_RCD;
            end
            ACTIVATING: t_act_done = time_done;
            READ: begin
                time_en   = 1'b1;
                time_load = LD_RL;
            end
            READING: begin
                t_rd_done = time_done;
                rd_en     = (time_count <= BEAT_LEN) && (time_count != '0);
            end
            WRITE: begin
                time_en   = 1'b1;
                time_load = LD_WL;
            end
            WRITING: begin
                t_wr_done = time_done;
                wr_en     = (time_count <= BEAT_LEN) && (time_count != '0);
            end
            PRECHARGE: begin
                time_en = 1'b1;
                // stretch the wait if the row has not been open for tRAS
                time_load = (ras_left > LD_RP) ? ras_left : LD_RP;
            end
            PRECHARGING: t_pre_done = time_done;
            REFRESH: begin
                time_en   = 1'b1;
                time_load = LD_RFC;
            end
            REFRESHING: t_ref_done = time_done;
            default: ;
        endcase
    end

    // cycles of tRAS still owed since the last ACT
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ras_left <= '0;
        end else if (cmd_state == ACTIVATE) begin
            ras_left <= RAS_START;
        end else if (ras_left != '0) begin
            ras_left <= ras_left - 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            refresh_count <= '0;
            refresh_limit <= REFI_V;
        end else begin
            refresh_count <= next_refresh_count;
            refresh_limit <= next_refresh_limit;
        end
    end

    always_comb begin
        next_refresh_limit = refresh_limit;
        next_refresh_count = refresh_count + 1'b1;

        if (cmd_state == REFRESH || cmd_state == REFRESHING) begin
            next_refresh_count = '0;
        end

        // late refresh pulls the next one in by the same amount
        if (cmd_state == REFRESH) begin
            if (refresh_count > REFI_V) begin
                next_refresh_limit = REFI_V - (refresh_count - REFI_V);
            end else begin
                next_refresh_limit = REFI_V;
            end
        end

        rf_req = (refresh_count >= refresh_limit) && (cmd_state != REFRESH);
    end

    flex_counter #(.N(CW)) time_counter (
        .CLK        (CLK),
        .nRST       (nRST),
        .enable     (time_en),
        .count_load (time_load),
        .count      (time_count),
        .count_done (time_done)
    );

endmodule

/* hw/command_fsm.sv */
module command_fsm
    import dram_cmd_pkg::*, dram_addr_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  wb_req_t    req,
    input  logic       req_valid,
    output logic       done,
    output cmd_state_t cmd_state,
    input  logic       t_act_done,
    input  logic       t_rd_done,
    input  logic       t_wr_done,
    input  logic       t_pre_done,
    input  logic       t_ref_done,
    input  logic       rf_req,
    output dram_cmd_t  dram_cmd
);

    cmd_state_t next_state;
    logic       carries_addr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cmd_state <= IDLE;
        end else begin
            cmd_state <= next_state;
        end
    end

    always_comb begin
        next_state = cmd_state;
        case (cmd_state)
            IDLE: begin
                // refresh goes ahead of a waiting request
                if (rf_req) begin
                    next_state = REFRESH;
                end else if (req_valid) begin
                    next_state = ACTIVATE;
                end
            end
            ACTIVATE:   next_state = ACTIVATING;
            ACTIVATING: begin
                if (t_act_done) begin
                    next_state = req.we ? WRITE : READ;
                end
            end
            READ:    next_state = READING;
            READING: begin
                if (t_rd_done) begin
                    next_state = PRECHARGE;
                end
            end
            WRITE:   next_state = WRITING;
            WRITING: begin
                if (t_wr_done) begin
                    next_state = PRECHARGE;
                end
            end
            // closed page, the row goes away after every access
            PRECHARGE:   next_state = PRECHARGING;
            PRECHARGING: begin
                if (t_pre_done) begin
                    next_state = IDLE;
                end
            end
            REFRESH:    next_state = REFRESHING;
            REFRESHING: begin
                if (t_ref_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // access finishes when the bank is closed again
    assign done = (cmd_state == PRECHARGING) && t_pre_done;

    // command port, NOP outside the issue cycles
    always_comb begin
        dram_cmd     = '0;
        dram_cmd.op  = NOP;
        carries_addr = 1'b0;
        case (cmd_state)
            ACTIVATE: begin
                dram_cmd.op  = ACT;
                carries_addr = 1'b1;
            end
            READ: begin
                dram_cmd.op  = RD;
                carries_addr = 1'b1;
            end
            WRITE: begin
                dram_cmd.op  = WR;
                carries_addr = 1'b1;
            end
            PRECHARGE: begin
                dram_cmd.op  = PRE;
                carries_addr = 1'b1;
            end
            REFRESH: dram_cmd.op = REF;
            default: ;
        endcase
        if (carries_addr) begin
            dram_cmd.bank = req.addr.loc.bank;
            dram_cmd.row  = req.addr.loc.row;
            dram_cmd.col  = req.addr.loc.col;
        end
    end

endmodule

/* hw/wb_dram_bridge.sv */
module wb_dram_bridge
    import dram_addr_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  dram_word_t  dat_w,
    output dram_word_t  dat_r,
    output logic        ack,
    output wb_req_t     req,
    output logic        req_valid,
    input  logic        done,
    input  logic        rd_en,
    input  dram_word_t  dram_rdata
);

    // word index sits just above the byte offset
    localparam int AW = $bits(dram_addr_u);

    logic busy;
    logic accept;

    // ack cycle still has stb up, so keep it from starting a new access
    assign accept    = cyc && stb && !busy && !ack;
    assign req_valid = busy;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            ack  <= 1'b0;
        end else begin
            ack <= done;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            req.we        <= we;
            req.addr.word <= adr[AW+1:2];
            req.wdata     <= dat_w;
        end
        // read beat lands here and stays until the next read
        if (rd_en) begin
            dat_r <= dram_rdata;
        end
    end

endmodule

/* hw/dram_ctrl_top.sv */
module dram_ctrl_top
    import dram_cmd_pkg::*, dram_addr_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  dram_word_t  dat_w,
    output dram_word_t  dat_r,
    output logic        ack,
    output dram_cmd_t   dram_cmd,
    output dram_word_t  dram_wdata,
    output logic        dram_we,
    output logic        dram_re,
    input  dram_word_t  dram_rdata
);

    wb_req_t    req;
    logic       req_valid;
    logic       done;
    cmd_state_t cmd_state;
    logic       t_act_done;
    logic       t_rd_done;
    logic       t_wr_done;
    logic       t_pre_done;
    logic       t_ref_done;
    logic       rf_req;
    logic       rd_en;
    logic       wr_en;

    // data side of the DRAM port
    assign dram_wdata = req.wdata;
    assign dram_we    = wr_en;
    assign dram_re    = rd_en;

    wb_dram_bridge bridge0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .req        (req),
        .req_valid  (req_valid),
        .done       (done),
        .rd_en      (rd_en),
        .dram_rdata (dram_rdata)
    );

    command_fsm cfsm0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .req        (req),
        .req_valid  (req_valid),
        .done       (done),
        .cmd_state  (cmd_state),
        .t_act_done (t_act_done),
        .t_rd_done  (t_rd_done),
        .t_wr_done  (t_wr_done),
        .t_pre_done (t_pre_done),
        .t_ref_done (t_ref_done),
        .rf_req     (rf_req),
        .dram_cmd   (dram_cmd)
    );

    timing_signal timing0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .cmd_state  (cmd_state),
        .t_act_done (t_act_done),
        .t_rd_done  (t_rd_done),
        .t_wr_done  (t_wr_done),
        .t_pre_done (t_pre_done),
        .t_ref_done (t_ref_done),
        .rf_req     (rf_req),
        .rd_en      (rd_en),
        .wr_en      (wr_en)
    );

endmodule

/* verif/dram_ctrl_assertions.sv */
`include "dram_consts.svh"

module dram_ctrl_assertions
    import dram_cmd_pkg::*;
(
    input logic      CLK,
    input logic      nRST,
    input dram_cmd_t dram_cmd
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int REF_GAP_MAX = `DRAM_T_REFI + 1 + `DRAM_T_RFC + 17;

    logic row_open;
    int   since_ref;

    // open between ACT and PRE
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            row_open  <= 1'b0;
            since_ref <= 0;
        end else begin
            if (dram_cmd.op == ACT) begin
                row_open <= 1'b1;
            end else if (dram_cmd.op == PRE) begin
                row_open <= 1'b0;
            end
            since_ref <= (dram_cmd.op == REF) ? 0 : since_ref + 1;
        end
    end

    act_needs_closed_row: assert property (@(posedge CLK) disable iff (!nRST)
        dram_cmd.op == ACT |-> !row_open)
        else $error("ACT issued while a row is still open");

    rdwr_needs_open_row: assert property (@(posedge CLK) disable iff (!nRST)
        (dram_cmd.op == RD || dram_cmd.op == WR) |-> row_open)
        else $error("RD or WR issued without an open row");

    ref_needs_closed_row: assert property (@(posedge CLK) disable iff (!nRST)
        dram_cmd.op == REF |-> !row_open)
        else $error("REF issued while a row is open");

    ref_spacing: assert property (@(posedge CLK) disable iff (!nRST)
        since_ref <= REF_GAP_MAX)
        else $error("REF spacing exceeded");

endmodule

/* verif/dram_ctrl_tb.sv */
`include "dram_consts.svh"

module dram_ctrl_tb
    import dram_cmd_pkg::*, dram_addr_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_LIMIT   = 100;
    localparam int LAT_RD      = 17;
    localparam int LAT_WR      = 16;
    localparam int REF_GAP_MAX = `DRAM_T_REFI + 1 + `DRAM_T_RFC + 17;

    logic        CLK = 1'b0;
    logic        nRST = 1'b0;
    logic        cyc = 1'b0;
    logic        stb = 1'b0;
    logic        we = 1'b0;
    logic [31:0] adr = '0;
    dram_word_t  dat_w = '0;
    dram_word_t  dat_r;
    logic        ack;
    dram_cmd_t   dram_cmd;
    dram_word_t  dram_wdata;
    logic        dram_we;
    logic        dram_re;
    dram_word_t  dram_rdata = '0;

    // memory model state by flat word address
    dram_word_t  mem [int unsigned];
    int unsigned open_word = 0;
    dram_cmd_t   cmd_log [$];
    int          cycle = 0;
    int          last_ref = 0;
    int          ref_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          cases_run = 0;
    bit          aborted = 1'b0;

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle = cycle + 1;
    end

    dram_ctrl_top dut0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .dram_cmd   (dram_cmd),
        .dram_wdata (dram_wdata),
        .dram_we    (dram_we),
        .dram_re    (dram_re),
        .dram_rdata (dram_rdata)
    );

    bind command_fsm dram_ctrl_assertions order_check0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .dram_cmd (dram_cmd)
    );

    // command log, data beats and refresh spacing
    always @(negedge CLK) begin
        if (nRST) begin
            if (dram_cmd.op != NOP) begin
                cmd_log.push_back(dram_cmd);
            end
            if (dram_cmd.op == RD || dram_cmd.op == WR) begin
                open_word = 32'({dram_cmd.row, dram_cmd.bank, dram_cmd.col});
            end
            if (dram_cmd.op == REF) begin
                if (ref_count > 0 && cycle - last_ref > REF_GAP_MAX) begin
                    $display("refresh gap of %0d cycles is longer than %0d at %0t",
                             cycle - last_ref, REF_GAP_MAX, $time);
                    errors++;
                end
                last_ref = cycle;
                ref_count++;
            end
            if (dram_we) begin
                mem[open_word] = dram_wdata;
            end
            if (dram_re && mem.exists(open_word)) begin
                dram_rdata = mem[open_word];
            end else begin
                dram_rdata = '0;
            end
        end
    end

    task automatic check_word(input string what, input dram_word_t got, input dram_word_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error @ %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_cmd(input dram_cmd_t got, input dram_cmd_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error @ %0t: command %s b%0d r%h c%h expected %s b%0d r%h c%h",
                     $time, got.op.name(), got.bank, got.row, got.col,
                     exp.op.name(), exp.bank, exp.row, exp.col);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("** Error @ %0t: %s is %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // count negedges until ack shows up mid-cycle
    task automatic wait_for_ack(output int cycles, output bit ok);
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (!ack && cycles < ACK_LIMIT);
        ok = ack;
        if (!ok) begin
            $display("no ack within %0d cycles of the request at %0t", ACK_LIMIT, $time);
        end
    endtask

    task automatic run_access(input int idx, input bit wr, input logic [31:0] a,
                              input dram_word_t wd, input dram_word_t ex);
        int        n;
        bit        ok;
        int        start_ref;
        bit        ref_busy;
        int        err_before;
        int        seen;
        dram_cmd_t exp_cmd;
        logic [21:0] w;

        err_before = errors;
        start_ref  = ref_count;
        // a REF just before the request keeps the FSM busy for tRFC
        ref_busy   = (ref_count > 0) && (cycle - last_ref < `DRAM_T_RFC);
        cmd_log.delete();
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = wd;
        wait_for_ack(n, ok);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        if (!ok) begin
            aborted = 1'b1;
        end else begin
            if (!wr) begin
                check_word("read data", dat_r, ex);
            end
            // request cycle counts as the first one
            if (ref_count == start_ref && !ref_busy) begin
                check_count("access latency", n + 1, wr ? LAT_WR : LAT_RD);
            end
            w = a[23:2];
            exp_cmd.row  = w[21:10];
            exp_cmd.bank = w[9:8];
            exp_cmd.col  = w[7:0];
            seen = 0;
            foreach (cmd_log[i]) begin
                if (cmd_log[i].op != REF) begin
                    case (seen)
                        0: exp_cmd.op = ACT;
                        1: exp_cmd.op = wr ? WR : RD;
                        default: exp_cmd.op = PRE;
                    endcase
                    check_cmd(cmd_log[i], exp_cmd);
                    seen++;
                end
            end
            check_count("commands per access", seen, 3);
        end
        $display("case %0d %s adr=%h: %s", idx, wr ? "write" : "read", a,
                 (errors == err_before && ok) ? "ok" : "FAIL");
    endtask

    initial begin
        int          fd;
        int          idx;
        int          op;
        int          start_ref;
        string       line;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] ex;
        dram_cmd_t   nop_cmd;

        void'($urandom(32'h7a1b_fa93));
        nop_cmd = '0;
        nop_cmd.op = NOP;
        repeat (2) @(negedge CLK);
        nRST = 1'b1;

        // quiet bus before the first request
        repeat (3) begin
            @(negedge CLK);
            check_count("ack after reset", int'(ack), 0);
            check_cmd(dram_cmd, nop_cmd);
        end

        idx = 0;
        fd = $fopen("verif/dram_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/dram_cases.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() == 0 || line.substr(0, 0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%d %h %h %h", op, a, wd, ex) != 4) begin
                continue;
            end
            idx++;
            cases_run++;
            if (op == 2) begin
                // address column holds the idle length
                start_ref = ref_count;
                repeat (a) @(negedge CLK);
                if (ref_count == start_ref) begin
                    $display("no REF seen during an idle gap of %0d cycles", a);
                    errors++;
                end
                $display("case %0d idle %0d cycles: %0d REF seen", idx, a,
                         ref_count - start_ref);
            end else begin
                run_access(idx, op == 0, a, wd, ex);
                repeat ($urandom_range(30, 0)) @(negedge CLK);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("cases %0d, checks %0d, errors %0d, refreshes %0d",
                 cases_run, checks, errors, ref_count);
        if (errors == 0 && !aborted && cases_run > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verif/dram_cases.txt */
# op (0 write, 1 read, 2 idle) | byte address or idle cycles | write data | expected read
0 00000000 11111111 00000000
1 00000000 00000000 11111111
0 00abcdec deadbeef 00000000
0 00000404 cafef00d 00000000
1 00abcdec 00000000 deadbeef
1 00000404 00000000 cafef00d
0 00fffffc a5a55a5a 00000000
2 0000012c 00000000 00000000
1 00fffffc 00000000 a5a55a5a
0 00abcdec 01234567 00000000
1 00abcdec 00000000 01234567
1 00000008 00000000 00000000
2 00000190 00000000 00000000
1 00000000 00000000 11111111
1 00000404 00000000 cafef00d

/* verilog.f */
+incdir+hw
hw/dram_cmd_pkg.sv
hw/dram_addr_pkg.sv
hw/flex_counter.sv
hw/timing_signal.sv
hw/command_fsm.sv
hw/wb_dram_bridge.sv
hw/dram_ctrl_top.sv
verif/dram_ctrl_assertions.sv
verif/dram_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dram_ctrl_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j 0 --Mdir $(OBJ_DIR) \
		-f $(FILELIST) --top-module $(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
